/* design/matrix_consts.svh */
// ========================================
// Widths, limits and reset values shared by the matrix store.
// Include wherever a MAT_ macro is needed.
// ========================================
`ifndef MATRIX_CONSTS_SVH
`define MATRIX_CONSTS_SVH

// Element and dimension widths
`define MAT_ELEM_WIDTH  8
`define MAT_DIM_WIDTH   3
`define MAT_MAX_DIM     5

// Slot pool geometry, 8 slots of 32 words each
`define MAT_SLOTS       8
`define MAT_SLOT_WIDTH  3
`define MAT_SLOT_STRIDE 32
`define MAT_ADDR_WIDTH  8

// Credits granted on each credited link
`define MAT_CREDITS     4

// Reset value of the element LFSR
`define MAT_LFSR_SEED   16'hACE1

`endif

/* design/matrix_pkg.sv */
// ========================================
// Shared types for the matrix store.
// Modules refer to them as matrix_pkg::name.
// ========================================
`include "matrix_consts.svh"

package matrix_pkg;

    typedef logic [`MAT_ELEM_WIDTH-1:0] elem_t;
    typedef logic [`MAT_DIM_WIDTH-1:0]  dim_t;
    typedef logic [`MAT_SLOT_WIDTH-1:0] slot_t;
    typedef logic [`MAT_ADDR_WIDTH-1:0] addr_t;

    // Matrix size carried in a header flit
    typedef struct packed {
        logic [1:0] spare;
        dim_t       m;
        dim_t       n;
    } mat_hdr_t;

    // First beat is a header, every later beat an element
    typedef union packed {
        mat_hdr_t hdr;
        elem_t    elem;
    } flit_payload_u;

    typedef struct packed {
        logic          is_hdr;
        logic          last;
        flit_payload_u payload;
    } mat_flit_t;

    // Generate request, elements bounded by max_value
    typedef struct packed {
        dim_t  m;
        dim_t  n;
        elem_t max_value;
    } gen_cmd_t;

    typedef struct packed {
        slot_t slot;
        logic  transpose;
    } rd_cmd_t;

    typedef struct packed {
        logic valid;
        dim_t m;
        dim_t n;
    } slot_info_t;

endpackage

/* design/matrix_generator.sv */
// ========================================
// Turns a generate command into a header flit and m*n random elements.
// Flits go to the pool under credit flow control.
// ========================================
`include "matrix_consts.svh"

module matrix_generator (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  gen_valid,
    input  matrix_pkg::gen_cmd_t  gen_cmd,
    input  logic                  gen_credit,
    output logic                  gen_busy,
    output logic                  cmd_error,
    output logic                  gen_flit_valid,
    output matrix_pkg::mat_flit_t gen_flit
);

    localparam int CRED_W = $clog2(`MAT_CREDITS + 1);

    matrix_pkg::gen_cmd_t cmd_q;
    matrix_pkg::dim_t     row;
    matrix_pkg::dim_t     col;
    logic                 hdr_pend;
    logic [15:0]          lfsr;
    logic                 lfsr_fb;
    logic [CRED_W-1:0]    credits;
    logic                 accept;
    logic                 dims_ok;
    logic                 send;
    logic                 last_elem;
    logic [8:0]           elem_wide;

    assign accept  = gen_valid && !gen_busy;
    assign dims_ok = (gen_cmd.m != '0) && (gen_cmd.n != '0) &&
                     (gen_cmd.m <= `MAT_MAX_DIM) && (gen_cmd.n <= `MAT_MAX_DIM);

    // One flit per cycle while a credit is held
    assign send           = gen_busy && (credits != '0);
    assign gen_flit_valid = send;

    assign last_elem = (row == cmd_q.m - 1'b1) && (col == cmd_q.n - 1'b1);

    // Taps 16, 14, 13, 11
    assign lfsr_fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    assign elem_wide = {1'b0, lfsr[7:0]} % ({1'b0, cmd_q.max_value} + 9'd1);

    always_comb begin
        gen_flit        = '0;
        gen_flit.is_hdr = hdr_pend;
        if (hdr_pend) begin
            gen_flit.payload.hdr.m = cmd_q.m;
            gen_flit.payload.hdr.n = cmd_q.n;
        end else begin
            gen_flit.payload.elem = elem_wide[`MAT_ELEM_WIDTH-1:0];
            gen_flit.last         = last_elem;
        end
    end

    // ========================================
    // Command, walk and LFSR
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_q     <= '0;
            gen_busy  <= 1'b0;
            cmd_error <= 1'b0;
            hdr_pend  <= 1'b0;
            row       <= '0;
            col       <= '0;
            lfsr      <= `MAT_LFSR_SEED;
        end else begin
            cmd_error <= accept && !dims_ok;
            if (accept && dims_ok) begin
                cmd_q    <= gen_cmd;
                gen_busy <= 1'b1;
                hdr_pend <= 1'b1;
                row      <= '0;
                col      <= '0;
            end else if (send) begin
                if (hdr_pend) begin
                    hdr_pend <= 1'b0;
                end else begin
                    // LFSR steps only on element beats
                    lfsr <= {lfsr[14:0], lfsr_fb};
                    if (last_elem) begin
                        gen_busy <= 1'b0;
                    end else if (col == cmd_q.n - 1'b1) begin
                        col <= '0;
                        row <= row + 1'b1;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
            end
        end
    end

    // Credits come back from the pool as it pops its FIFO
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CRED_W'(`MAT_CREDITS);
        end else if (gen_credit && !send) begin
            credits <= credits + 1'b1;
        end else if (!gen_credit && send) begin
            credits <= credits - 1'b1;
        end
    end

endmodule

/* design/matrix_pool.sv */
// ========================================
// Matrix pool with flit FIFO, round-robin slot table and element memory.
// The reader gets a one-cycle read port and a slot info lookup.
// ========================================
`include "matrix_consts.svh"

module matrix_pool (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   gen_flit_valid,
    input  matrix_pkg::mat_flit_t  gen_flit,
    input  logic                   rd_en,
    input  matrix_pkg::addr_t      rd_addr,
    input  matrix_pkg::slot_t      info_slot,
    output logic                   gen_credit,
    output matrix_pkg::elem_t      rd_data,
    output matrix_pkg::slot_info_t info,
    output logic                   commit_valid,
    output matrix_pkg::slot_t      commit_slot
);

    localparam int PTR_W = $clog2(`MAT_CREDITS);
    localparam int CNT_W = $clog2(`MAT_CREDITS + 1);

    matrix_pkg::mat_flit_t  fifo_mem [`MAT_CREDITS];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   pop;
    logic                   elem_we;
    matrix_pkg::mat_flit_t  head;

    matrix_pkg::slot_t      slot_ptr;
    matrix_pkg::slot_t      cur_slot;
    matrix_pkg::addr_t      wr_addr;
    matrix_pkg::slot_info_t slot_table [`MAT_SLOTS];
    matrix_pkg::elem_t      elem_mem [2**`MAT_ADDR_WIDTH];

    // Drain one entry per cycle, credit goes back at once
    assign pop        = (count != '0);
    assign gen_credit = pop;
    assign head       = fifo_mem[rd_ptr];
    assign elem_we    = pop && !head.is_hdr;

    assign info = slot_table[info_slot];

    // ========================================
    // Storage arrays
    // ========================================
    always_ff @(posedge clk) begin
        if (gen_flit_valid) begin
            fifo_mem[wr_ptr] <= gen_flit;
        end
        if (elem_we) begin
            elem_mem[wr_addr] <= head.payload.elem;
        end
        if (rd_en) begin
            rd_data <= elem_mem[rd_addr];
        end
    end

    // ========================================
    // FIFO pointers and slot bookkeeping
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            slot_ptr     <= '0;
            cur_slot     <= '0;
            wr_addr      <= '0;
            commit_valid <= 1'b0;
            commit_slot  <= '0;
            for (int i = 0; i < `MAT_SLOTS; i++) begin
                slot_table[i] <= '0;
            end
        end else begin
            if (gen_flit_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (gen_flit_valid && !pop) begin
                count <= count + 1'b1;
            end else if (!gen_flit_valid && pop) begin
                count <= count - 1'b1;
            end

            commit_valid <= 1'b0;
            if (pop && head.is_hdr) begin
                // Header claims the next slot, which stays invalid until commit
                cur_slot             <= slot_ptr;
                slot_ptr             <= slot_ptr + 1'b1;
                wr_addr              <= matrix_pkg::addr_t'(slot_ptr * `MAT_SLOT_STRIDE);
                slot_table[slot_ptr] <= '{valid: 1'b0,
                                          m: head.payload.hdr.m,
                                          n: head.payload.hdr.n};
            end else if (elem_we) begin
                wr_addr <= wr_addr + 1'b1;
                if (head.last) begin
                    commit_valid               <= 1'b1;
                    commit_slot                <= cur_slot;
                    slot_table[cur_slot].valid <= 1'b1;
                end
            end
        end
    end

endmodule

/* design/matrix_reader.sv */
// ========================================
// Streams a stored matrix out, row-major or transposed.
// Output flits are sent under credits from the consumer.
// ========================================
`include "matrix_consts.svh"

module matrix_reader (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rd_valid,
    input  matrix_pkg::rd_cmd_t    rd_cmd,
    input  matrix_pkg::slot_info_t info,
    input  matrix_pkg::elem_t      rd_data,
    input  logic                   out_credit,
    output logic                   rd_busy,
    output matrix_pkg::slot_t      info_slot,
    output logic                   rd_en,
    output matrix_pkg::addr_t      rd_addr,
    output logic                   out_valid,
    output matrix_pkg::mat_flit_t  out_flit
);

    localparam int CRED_W = $clog2(`MAT_CREDITS + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_HDR,
        S_ELEM,
        S_DRAIN
    } state_t;

    state_t               state;
    matrix_pkg::rd_cmd_t  cmd_q;
    matrix_pkg::dim_t     m_q;
    matrix_pkg::dim_t     n_q;
    matrix_pkg::dim_t     row;
    matrix_pkg::dim_t     col;
    matrix_pkg::mat_hdr_t hdr;
    logic [CRED_W-1:0]    credits;
    logic [1:0]           in_flight;
    logic                 can_issue;
    logic                 hdr_issue;
    logic                 last_elem;
    logic                 p1_valid;
    logic                 p1_last;

    assign rd_busy   = (state != S_IDLE);
    assign info_slot = cmd_q.slot;

    // Flits issued but not yet sent: the read stage plus the output register
    assign in_flight = {1'b0, p1_valid} + {1'b0, out_valid};
    assign can_issue = credits > CRED_W'(in_flight);
    assign hdr_issue = (state == S_HDR) && can_issue;
    assign rd_en     = (state == S_ELEM) && can_issue;

    // Both orders finish on the bottom right element
    assign last_elem = (row == m_q - 1'b1) && (col == n_q - 1'b1);
    assign rd_addr   = matrix_pkg::addr_t'(cmd_q.slot * `MAT_SLOT_STRIDE) +
                       matrix_pkg::addr_t'(row) * matrix_pkg::addr_t'(n_q) +
                       matrix_pkg::addr_t'(col);

    // Empty slot reports 0 by 0
    always_comb begin
        hdr = '0;
        if (info.valid) begin
            hdr.m = cmd_q.transpose ? info.n : info.m;
            hdr.n = cmd_q.transpose ? info.m : info.n;
        end
    end

    // ========================================
    // Sequencer and credit counter
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            cmd_q     <= '0;
            m_q       <= '0;
            n_q       <= '0;
            row       <= '0;
            col       <= '0;
            p1_valid  <= 1'b0;
            p1_last   <= 1'b0;
            out_valid <= 1'b0;
            credits   <= CRED_W'(`MAT_CREDITS);
        end else begin
            p1_valid  <= rd_en;
            p1_last   <= rd_en && last_elem;
            out_valid <= hdr_issue || p1_valid;
            if (out_credit && !out_valid) begin
                credits <= credits + 1'b1;
            end else if (!out_credit && out_valid) begin
                credits <= credits - 1'b1;
            end

            case (state)
                S_IDLE: begin
                    if (rd_valid) begin
                        cmd_q <= rd_cmd;
                        state <= S_HDR;
                    end
                end
                S_HDR: begin
                    if (hdr_issue) begin
                        m_q   <= info.m;
                        n_q   <= info.n;
                        row   <= '0;
                        col   <= '0;
                        state <= info.valid ? S_ELEM : S_DRAIN;
                    end
                end
                S_ELEM: begin
                    if (rd_en) begin
                        if (last_elem) begin
                            state <= S_DRAIN;
                        end else if (cmd_q.transpose) begin
                            // Column-major walk
                            if (row == m_q - 1'b1) begin
                                row <= '0;
                                col <= col + 1'b1;
                            end else begin
                                row <= row + 1'b1;
                            end
                        end else if (col == n_q - 1'b1) begin
                            col <= '0;
                            row <= row + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                default: begin
                    if (out_valid && out_flit.last) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Output flit, header or returned element with its last tag
    always_ff @(posedge clk) begin
        if (hdr_issue) begin
            out_flit.is_hdr      <= 1'b1;
            out_flit.last        <= !info.valid;
            out_flit.payload.hdr <= hdr;
        end else if (p1_valid) begin
            out_flit.is_hdr       <= 1'b0;
            out_flit.last         <= p1_last;
            out_flit.payload.elem <= rd_data;
        end
    end

endmodule

/* design/matrix_store_top.sv */
// ========================================
// Matrix store top level.
// Generator feeds the pool, reader streams stored matrices out.
// ========================================
module matrix_store_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  gen_valid,
    input  matrix_pkg::gen_cmd_t  gen_cmd,
    input  logic                  rd_valid,
    input  matrix_pkg::rd_cmd_t   rd_cmd,
    input  logic                  out_credit,
    output logic                  gen_busy,
    output logic                  cmd_error,
    output logic                  commit_valid,
    output matrix_pkg::slot_t     commit_slot,
    output logic                  rd_busy,
    output logic                  out_valid,
    output matrix_pkg::mat_flit_t out_flit
);

    // Generator to pool link
    logic                   gen_flit_valid;
    matrix_pkg::mat_flit_t  gen_flit;
    logic                   gen_credit;

    // Pool to reader link
    logic                   rd_en;
    matrix_pkg::addr_t      rd_addr;
    matrix_pkg::elem_t      rd_data;
    matrix_pkg::slot_t      info_slot;
    matrix_pkg::slot_info_t info;

    matrix_generator u_generator (
        .clk            (clk),
        .rst_n          (rst_n),
        .gen_valid      (gen_valid),
        .gen_cmd        (gen_cmd),
        .gen_credit     (gen_credit),
        .gen_busy       (gen_busy),
        .cmd_error      (cmd_error),
        .gen_flit_valid (gen_flit_valid),
        .gen_flit       (gen_flit)
    );

    matrix_pool u_pool (
        .clk            (clk),
        .rst_n          (rst_n),
        .gen_flit_valid (gen_flit_valid),
        .gen_flit       (gen_flit),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .info_slot      (info_slot),
        .gen_credit     (gen_credit),
        .rd_data        (rd_data),
        .info           (info),
        .commit_valid   (commit_valid),
        .commit_slot    (commit_slot)
    );

    matrix_reader u_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_valid   (rd_valid),
        .rd_cmd     (rd_cmd),
        .info       (info),
        .rd_data    (rd_data),
        .out_credit (out_credit),
        .rd_busy    (rd_busy),
        .info_slot  (info_slot),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .out_valid  (out_valid),
        .out_flit   (out_flit)
    );

endmodule

/* test/matrix_store_assertions.sv */
// ========================================
// Concurrent checks on a credited flit stream.
// Bound below to the generator and the reader.
// ========================================
`include "matrix_consts.svh"

module matrix_store_assertions #(
    parameter int CRED_W = $clog2(`MAT_CREDITS + 1)
) (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  busy,
    input logic                  flit_valid,
    input matrix_pkg::mat_flit_t flit,
    input logic [CRED_W-1:0]     credits
);

    // Set from a header until its last flit
    logic stream_open;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stream_open <= 1'b0;
        end else if (flit_valid) begin
            stream_open <= !flit.last;
        end
    end

    credit_range: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CRED_W'(`MAT_CREDITS))
        else $error("credit counter above its grant");

    credit_held: assert property (@(posedge clk) disable iff (!rst_n)
        flit_valid |-> (credits != '0))
        else $error("flit sent with no credit held");

    // Exactly one last flit per stream
    hdr_opens: assert property (@(posedge clk) disable iff (!rst_n)
        (flit_valid && flit.is_hdr) |-> !stream_open)
        else $error("header inside an open stream");

    elem_inside: assert property (@(posedge clk) disable iff (!rst_n)
        (flit_valid && !flit.is_hdr) |-> stream_open)
        else $error("element flit after the last flit");

    closed_at_end: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> !stream_open)
        else $error("stream finished without a last flit");

    idle_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!flit_valid && !busy))
        else $error("valid output during reset");

endmodule

bind matrix_generator matrix_store_assertions u_gen_checks (
    .clk        (clk),
    .rst_n      (rst_n),
    .busy       (gen_busy),
    .flit_valid (gen_flit_valid),
    .flit       (gen_flit),
    .credits    (credits)
);

bind matrix_reader matrix_store_assertions u_rd_checks (
    .clk        (clk),
    .rst_n      (rst_n),
    .busy       (rd_busy),
    .flit_valid (out_valid),
    .flit       (out_flit),
    .credits    (credits)
);

/* test/matrix_store_tb.sv */
// ========================================
// Testbench for the matrix store. Random generate and read commands
// are checked against a model of the element LFSR and the slot pool.
// ========================================
`include "matrix_consts.svh"

module matrix_store_tb;

    localparam int NUM_TESTS       = 18;
    localparam int CYCLES_PER_TEST = 200;

    logic                  clk;
    logic                  rst_n;
    logic                  gen_valid;
    matrix_pkg::gen_cmd_t  gen_cmd;
    logic                  rd_valid;
    matrix_pkg::rd_cmd_t   rd_cmd;
    logic                  out_credit;
    logic                  gen_busy;
    logic                  cmd_error;
    logic                  commit_valid;
    matrix_pkg::slot_t     commit_slot;
    logic                  rd_busy;
    logic                  out_valid;
    matrix_pkg::mat_flit_t out_flit;

    // Reference model of LFSR and slot contents
    logic [15:0]           model_lfsr;
    logic                  model_valid [`MAT_SLOTS];
    int                    model_m [`MAT_SLOTS];
    int                    model_n [`MAT_SLOTS];
    matrix_pkg::elem_t     model_elem [`MAT_SLOTS][`MAT_SLOT_STRIDE];
    int                    rr_ptr;

    // Observed events
    matrix_pkg::mat_flit_t got [$];
    matrix_pkg::slot_t     seen_slot;
    int                    commits;
    int                    errors_seen;
    int                    owed;
    bit                    withhold;

    int                    test_errors;
    int                    total_errors;
    int                    tests_run;
    int                    tests_failed;
    int                    m;
    int                    n;
    int                    k;
    int                    slot;

    matrix_store_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .gen_valid    (gen_valid),
        .gen_cmd      (gen_cmd),
        .rd_valid     (rd_valid),
        .rd_cmd       (rd_cmd),
        .out_credit   (out_credit),
        .gen_busy     (gen_busy),
        .cmd_error    (cmd_error),
        .commit_valid (commit_valid),
        .commit_slot  (commit_slot),
        .rd_busy      (rd_busy),
        .out_valid    (out_valid),
        .out_flit     (out_flit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not finish",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_flit(input string name, input matrix_pkg::mat_flit_t exp_flit,
                              input matrix_pkg::mat_flit_t act_flit);
        if (act_flit !== exp_flit) begin
            $display("FAIL %s: expected %h, actual %h", name, exp_flit, act_flit);
            test_errors++;
        end
    endtask

    task automatic check_slot(input string name, input matrix_pkg::slot_t exp_slot,
                              input matrix_pkg::slot_t act_slot);
        if (act_slot !== exp_slot) begin
            $display("FAIL %s: expected slot %0d, actual slot %0d", name, exp_slot, act_slot);
            test_errors++;
        end
    endtask

    task automatic check_error(input string name, input logic exp_err, input logic act_err);
        if (act_err !== exp_err) begin
            $display("FAIL %s: expected cmd_error %b, actual %b", name, exp_err, act_err);
            test_errors++;
        end
    endtask

    task automatic check_busy(input string name, input logic exp_busy, input logic act_busy);
        if (act_busy !== exp_busy) begin
            $display("FAIL %s: expected busy %b, actual %b", name, exp_busy, act_busy);
            test_errors++;
        end
    endtask

    // Step one clock and sample outputs before returning credits
    task automatic tick();
        @(posedge clk);
        #1;
        if (commit_valid) begin
            commits++;
            seen_slot = commit_slot;
        end
        if (cmd_error) begin
            errors_seen++;
        end
        if (out_valid) begin
            got.push_back(out_flit);
            owed++;
            if (owed > `MAT_CREDITS) begin
                $display("ERROR: output flit sent while the reader held no credit");
                test_errors++;
            end
        end
        out_credit = 1'b0;
        if ((owed > 0) && (!withhold || (($urandom % 4) == 0))) begin
            out_credit = 1'b1;
            owed--;
        end
    endtask

    task automatic gen_matrix(input string name, input int gm, input int gn, input int maxv);
        int c0;
        int e0;
        int i;
        bit legal;
        legal = (gm >= 1) && (gm <= `MAT_MAX_DIM) && (gn >= 1) && (gn <= `MAT_MAX_DIM);
        while (gen_busy) begin
            tick();
        end
        c0                = commits;
        e0                = errors_seen;
        gen_cmd.m         = matrix_pkg::dim_t'(gm);
        gen_cmd.n         = matrix_pkg::dim_t'(gn);
        gen_cmd.max_value = matrix_pkg::elem_t'(maxv);
        gen_valid         = 1'b1;
        tick();
        gen_valid = 1'b0;
        check_busy({name, " gen_busy start"}, legal, gen_busy);
        if (legal) begin
            // Next round-robin slot gets m*n bounded LFSR values
            model_valid[rr_ptr] = 1'b1;
            model_m[rr_ptr]     = gm;
            model_n[rr_ptr]     = gn;
            for (i = 0; i < gm * gn; i++) begin
                model_elem[rr_ptr][i] = matrix_pkg::elem_t'(int'(model_lfsr[7:0]) % (maxv + 1));
                model_lfsr = {model_lfsr[14:0],
                              model_lfsr[15] ^ model_lfsr[13] ^ model_lfsr[12] ^ model_lfsr[10]};
            end
            while (commits == c0) begin
                tick();
            end
            check_slot(name, matrix_pkg::slot_t'(rr_ptr), seen_slot);
            check_error(name, 1'b0, errors_seen != e0);
            check_busy({name, " gen_busy end"}, 1'b0, gen_busy);
            rr_ptr = (rr_ptr + 1) % `MAT_SLOTS;
        end else begin
            // Any stream started by mistake must drain before the commit count is judged
            while (gen_busy) begin
                tick();
            end
            repeat (`MAT_CREDITS + 2) tick();
            check_error(name, 1'b1, errors_seen != e0);
            if (commits != c0) begin
                $display("ERROR %s: rejected command still stored a matrix", name);
                test_errors++;
            end
        end
    endtask

    task automatic read_stream(input string name, input int rs, input bit tr, input bit hold);
        while (rd_busy) begin
            tick();
        end
        got.delete();
        withhold         = hold;
        rd_cmd.slot      = matrix_pkg::slot_t'(rs);
        rd_cmd.transpose = tr;
        rd_valid         = 1'b1;
        tick();
        rd_valid = 1'b0;
        check_busy({name, " rd_busy start"}, 1'b1, rd_busy);
        while ((got.size() == 0) || !got[got.size() - 1].last) begin
            tick();
        end
        // Return every credit so the next read starts full
        withhold = 1'b0;
        tick();
        check_busy({name, " rd_busy end"}, 1'b0, rd_busy);
        while ((owed != 0) || rd_busy) begin
            tick();
        end
    endtask

    task automatic check_read(input string name, input int rs, input bit tr);
        matrix_pkg::mat_flit_t exp_flit;
        int em;
        int en;
        int total;
        int i;
        int idx;
        em = 0;
        en = 0;
        if (model_valid[rs]) begin
            em = tr ? model_n[rs] : model_m[rs];
            en = tr ? model_m[rs] : model_n[rs];
        end
        total = 1 + em * en;
        if (got.size() != total) begin
            $display("ERROR %s: stream held %0d flits instead of %0d", name, got.size(), total);
            test_errors++;
        end
        exp_flit                = '0;
        exp_flit.is_hdr         = 1'b1;
        exp_flit.last           = (total == 1);
        exp_flit.payload.hdr.m  = matrix_pkg::dim_t'(em);
        exp_flit.payload.hdr.n  = matrix_pkg::dim_t'(en);
        if (got.size() > 0) begin
            check_flit({name, " header"}, exp_flit, got[0]);
        end
        for (i = 1; (i < total) && (i < got.size()); i++) begin
            // Stream position back to row-major storage index
            idx = tr ? ((i - 1) % en) * em + (i - 1) / en : i - 1;
            exp_flit              = '0;
            exp_flit.last         = (i == total - 1);
            exp_flit.payload.elem = model_elem[rs][idx];
            check_flit($sformatf("%s elem %0d", name, i - 1), exp_flit, got[i]);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        void'($urandom(32'h7f));
        rst_n        = 1'b0;
        gen_valid    = 1'b0;
        gen_cmd      = '0;
        rd_valid     = 1'b0;
        rd_cmd       = '0;
        out_credit   = 1'b0;
        withhold     = 1'b0;
        owed         = 0;
        commits      = 0;
        errors_seen  = 0;
        seen_slot    = '0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_lfsr   = `MAT_LFSR_SEED;
        rr_ptr       = 0;
        for (k = 0; k < `MAT_SLOTS; k++) begin
            model_valid[k] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tick();

        m = 1 + ($urandom % `MAT_MAX_DIM);
        n = 1 + ($urandom % `MAT_MAX_DIM);
        gen_matrix("gen_rowmajor", m, n, $urandom % 256);
        read_stream("gen_rowmajor", 0, 1'b0, 1'b0);
        check_read("gen_rowmajor", 0, 1'b0);
        end_test("gen_rowmajor");

        read_stream("read_transpose", 0, 1'b1, 1'b0);
        check_read("read_transpose", 0, 1'b1);
        end_test("read_transpose");

        // Illegal sizes must leave the LFSR where it was
        gen_matrix("bad_m_zero", 0, 1 + ($urandom % `MAT_MAX_DIM), 255);
        end_test("bad_m_zero");
        gen_matrix("bad_n_six", 1 + ($urandom % `MAT_MAX_DIM), 6, 255);
        end_test("bad_n_six");
        gen_matrix("bad_both_seven", 7, 7, 255);
        end_test("bad_both_seven");

        slot = 1 + ($urandom % (`MAT_SLOTS - 1));
        read_stream("empty_slot", slot, 1'b0, 1'b0);
        check_read("empty_slot", slot, 1'b0);
        end_test("empty_slot");

        // Eight more matrices wrap the slot pointer back to 0
        for (k = 1; k <= 8; k++) begin
            m = 1 + ($urandom % `MAT_MAX_DIM);
            n = 1 + ($urandom % `MAT_MAX_DIM);
            gen_matrix($sformatf("fill_%0d", k), m, n, $urandom % 256);
            end_test($sformatf("fill_%0d", k));
        end
        read_stream("wrap_slot0", 0, 1'b0, 1'b0);
        check_read("wrap_slot0", 0, 1'b0);
        end_test("wrap_slot0");
        read_stream("wrap_slot1", 1, 1'b0, 1'b0);
        check_read("wrap_slot1", 1, 1'b0);
        end_test("wrap_slot1");

        // Output credits withheld at random
        slot = $urandom % `MAT_SLOTS;
        read_stream("backpressure_row", slot, 1'b0, 1'b1);
        check_read("backpressure_row", slot, 1'b0);
        end_test("backpressure_row");
        slot = $urandom % `MAT_SLOTS;
        read_stream("backpressure_tr", slot, 1'b1, 1'b1);
        check_read("backpressure_tr", slot, 1'b1);
        end_test("backpressure_tr");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+design
design/matrix_pkg.sv
design/matrix_generator.sv
design/matrix_pool.sv
design/matrix_reader.sv
design/matrix_store_top.sv
test/matrix_store_assertions.sv
test/matrix_store_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = matrix_store_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Build, run, then decide on the log contents
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -F -q "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
